//--- hdl/crtcPkg.sv
`default_nettype none

package crtcPkg;

	// register numbers of the 6845; 16 and 17 are the light-pen pair and read as zero
	typedef enum logic [4:0] {
		regHTotal       = 5'd0,
		regHDisplayed   = 5'd1,
		regHSyncPos     = 5'd2,
		regSyncWidth    = 5'd3,
		regVTotal       = 5'd4,
		regVTotalAdj    = 5'd5,
		regVDisplayed   = 5'd6,
		regVSyncPos     = 5'd7,
		regInterlace    = 5'd8,
		regMaxScanLine  = 5'd9,
		regCursorStart  = 5'd10,
		regCursorEnd    = 5'd11,
		regStartHigh    = 5'd12,
		regStartLow     = 5'd13,
		regCursorHigh   = 5'd14,
		regCursorLow    = 5'd15,
		regLightPenHigh = 5'd16,
		regLightPenLow  = 5'd17
	} crtcReg;

	// timing outputs of the CRTC
	// charEn marks the CLK in which new values appear
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic disEn;
		logic cursor;
		logic charEn;
	} crtcTiming;

endpackage

`default_nettype wire

//--- hdl/videoPkg.sv
`default_nettype none

package videoPkg;

	// one bit per gun, red in the top bit
	typedef logic [2:0] rgbPixel;

	// palette entry as written by the processor
	typedef struct packed {
		logic flash;
		rgbPixel rgb;
	} paletteEntry;

	// pixel rate, coded as in bits 3:2 of the control register
	typedef enum logic [1:0] {
		rate2Mhz  = 2'b00,
		rate4Mhz  = 2'b01,
		rate8Mhz  = 2'b10,
		rate16Mhz = 2'b11
	} shiftRate;

	// ULA control register, most significant field first
	typedef struct packed {
		logic [2:0] cursorSeg;
		logic fastCrtc;
		shiftRate pixelRate;
		logic teletext;
		logic flash;
	} ulaControl;

	// single-cycle strobes derived from the 16 MHz CLK
	typedef struct packed {
		logic en16;
		logic en8;
		logic en4;
		logic en2;
		logic en1;
		logic en2v;
	} clockEn;

endpackage

`default_nettype wire

//--- hdl/clockEnables.sv
`timescale 1ns/1ns
`default_nettype none

module clockEnables
	import videoPkg::*;
(
	input wire CLK,
	input wire nRESET,
	output clockEn en
);

	// position within the 16-cycle period of the 1 MHz strobe
	logic [3:0] phase;

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			phase <= '0;
		end else begin
			phase <= phase + 4'd1;
		end
	end

	always_comb begin
		en.en16 = 1'b1;
		en.en8 = phase[0];
		en.en4 = &phase[1:0];
		en.en2 = &phase[2:0];
		en.en1 = &phase;
		// fast character rate, twice per 1 MHz period
		en.en2v = &phase[2:0];
	end

	// the slow character strobe has to land on a fast one, so that
	// toggling fastCrtc never produces a short character period
	enNested: assert property (
		@(posedge CLK) disable iff (!nRESET)
		en.en1 |-> en.en2v
	);

endmodule

`default_nettype wire

//--- hdl/crtc6845.sv
`timescale 1ns/1ns
`default_nettype none

module crtc6845
	import crtcPkg::*;
#(
	parameter int FS_ADDR_W = 14
) (
	input wire CLK,
	input wire nRESET,
	input wire charEn,
	input wire procEn,
	input wire rnw,
	input wire a0,
	input wire ncsCrtc,
	input wire [7:0] cpuWrData,
	output logic [7:0] cpuRdData,
	output crtcTiming timing,
	output logic [FS_ADDR_W-1:0] fsAddr,
	output logic [4:0] rowAddr
);

	crtcReg addrLatch;
	logic [7:0] regFile [0:17];
	logic busWrite;

	logic [7:0] hCount;
	logic [6:0] vCount;
	logic [3:0] hSyncLeft;
	logic [4:0] vSyncLeft;
	logic [FS_ADDR_W-1:0] rowStart;
	logic [FS_ADDR_W-1:0] endAddr;

	logic lineEnd;
	logic rowEnd;
	logic frameEnd;
	logic [7:0] hNext;
	logic [4:0] rowNext;
	logic [6:0] vNext;
	logic [FS_ADDR_W-1:0] addrNext;
	logic [FS_ADDR_W-1:0] startAddr;
	logic [FS_ADDR_W-1:0] cursorAddr;
	logic [3:0] hSyncWidth;
	logic [4:0] vSyncWidth;

	assign busWrite = procEn && !rnw && !ncsCrtc;

	// registers 16 and 17 stay at zero, there is no light pen
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			addrLatch <= regHTotal;
			for (int i = 0; i < 18; i++) begin
				regFile[i] <= '0;
			end
		end else if (busWrite) begin
			if (!a0) begin
				addrLatch <= crtcReg'(cpuWrData[4:0]);
			end else if (addrLatch <= regCursorLow) begin
				regFile[addrLatch] <= cpuWrData;
			end
		end
	end

	// only the cursor and light-pen registers can be read back
	always_comb begin
		cpuRdData = 8'h00;
		if (!ncsCrtc && rnw && a0) begin
			case (addrLatch)
				regCursorHigh, regCursorLow, regLightPenHigh, regLightPenLow:
					cpuRdData = regFile[addrLatch];
				default:
					cpuRdData = 8'h00;
			endcase
		end
	end

	assign startAddr = FS_ADDR_W'({regFile[regStartHigh], regFile[regStartLow]});
	assign cursorAddr = FS_ADDR_W'({regFile[regCursorHigh], regFile[regCursorLow]});
	assign hSyncWidth = regFile[regSyncWidth][3:0];
	// a vertical width of zero means sixteen lines
	assign vSyncWidth = {regFile[regSyncWidth][7:4] == 4'd0, regFile[regSyncWidth][7:4]};

	// position of the character that starts at the next charEn
	always_comb begin
		lineEnd = hCount == regFile[regHTotal];
		rowEnd = lineEnd && (rowAddr == regFile[regMaxScanLine][4:0]);
		frameEnd = rowEnd && (vCount == regFile[regVTotal][6:0]);
		hNext = lineEnd ? 8'd0 : hCount + 8'd1;
		rowNext = rowEnd ? 5'd0 : (lineEnd ? rowAddr + 5'd1 : rowAddr);
		vNext = frameEnd ? 7'd0 : (rowEnd ? vCount + 7'd1 : vCount);
		if (frameEnd) begin
			addrNext = startAddr;
		end else if (rowEnd) begin
			addrNext = endAddr;
		end else if (lineEnd) begin
			addrNext = rowStart;
		end else begin
			addrNext = fsAddr + FS_ADDR_W'(1);
		end
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			hCount <= '0;
			vCount <= '0;
			rowAddr <= '0;
			fsAddr <= '0;
			rowStart <= '0;
			endAddr <= '0;
		end else if (charEn) begin
			hCount <= hNext;
			rowAddr <= rowNext;
			vCount <= vNext;
			fsAddr <= addrNext;
			if (frameEnd) begin
				rowStart <= startAddr;
			end else if (rowEnd) begin
				rowStart <= endAddr;
			end
			// first address past the displayed part, where the next row begins
			if (hNext == regFile[regHDisplayed]) begin
				endAddr <= addrNext;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			timing <= '0;
			hSyncLeft <= '0;
			vSyncLeft <= '0;
		end else begin
			timing.charEn <= charEn;
			if (charEn) begin
				timing.disEn <= (hNext < regFile[regHDisplayed]) &&
					(vNext < regFile[regVDisplayed][6:0]);
				timing.cursor <= (addrNext == cursorAddr) &&
					(rowNext >= regFile[regCursorStart][4:0]) &&
					(rowNext <= regFile[regCursorEnd][4:0]);

				// hsync counts characters down from the width latched at its rise
				if (!timing.hsync) begin
					if (hCount == regFile[regHSyncPos] && hSyncWidth != 4'd0) begin
						timing.hsync <= 1'b1;
						hSyncLeft <= hSyncWidth;
					end
				end else begin
					hSyncLeft <= hSyncLeft - 4'd1;
					if (hSyncLeft == 4'd1) begin
						timing.hsync <= 1'b0;
					end
				end

				// vsync starts with the first scan line of its character row
				if (!timing.vsync) begin
					if (rowEnd && vNext == regFile[regVSyncPos][6:0]) begin
						timing.vsync <= 1'b1;
						vSyncLeft <= vSyncWidth;
					end
				end else if (lineEnd) begin
					vSyncLeft <= vSyncLeft - 5'd1;
					if (vSyncLeft == 5'd1) begin
						timing.vsync <= 1'b0;
					end
				end
			end
		end
	end

	// the width is taken when the pulse starts, so a later write of zero
	// to the sync width register cannot leave hsync stuck high
	hSyncLive: assert property (
		@(posedge CLK) disable iff (!nRESET)
		timing.hsync |-> hSyncLeft != 4'd0
	);

endmodule

`default_nettype wire

//--- hdl/videoUla.sv
`timescale 1ns/1ns
`default_nettype none

module videoUla
	import crtcPkg::*, videoPkg::*;
(
	input wire CLK,
	input wire nRESET,
	input wire clockEn en,
	input wire crtcTiming timing,
	input wire [4:0] rowAddr,
	input wire procEn,
	input wire a0,
	input wire ncsUla,
	input wire [7:0] cpuWrData,
	input wire [7:0] vData,
	input wire rgbPixel ttxRgb,
	output logic charEn,
	output logic txtMode,
	output rgbPixel rgb
);

	ulaControl ctrl;
	paletteEntry palette [16];
	logic [7:0] shifter;
	logic [3:0] segShift;
	logic disEnReg;
	logic shiftEn;
	logic cursorDraw;
	logic displayed;
	paletteEntry colour;
	rgbPixel pixel;

	assign charEn = ctrl.fastCrtc ? en.en2v : en.en1;
	assign txtMode = ctrl.teletext;

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			ctrl <= '0;
		end else if (procEn && !ncsUla && !a0) begin
			ctrl <= ulaControl'(cpuWrData);
		end
	end

	// top nibble of the data selects the entry
	always_ff @(posedge CLK) begin
		if (procEn && !ncsUla && a0) begin
			palette[cpuWrData[7:4]] <= paletteEntry'(cpuWrData[3:0]);
		end
	end

	always_comb begin
		case (ctrl.pixelRate)
			rate2Mhz: shiftEn = en.en2;
			rate4Mhz: shiftEn = en.en4;
			rate8Mhz: shiftEn = en.en8;
			default: shiftEn = en.en16;
		endcase
	end

	// ones shift in so that a short character shows colour 15 at its end
	always_ff @(posedge CLK) begin
		if (charEn) begin
			shifter <= vData;
		end else if (shiftEn) begin
			shifter <= {shifter[6:0], 1'b1};
		end
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			disEnReg <= 1'b0;
			segShift <= '0;
		end else if (charEn) begin
			disEnReg <= timing.disEn;
			// teletext output lags a character, so it takes the delayed enable
			if (timing.cursor) begin
				segShift <= {3'b000, ctrl.teletext ? disEnReg : timing.disEn};
			end else begin
				segShift <= {segShift[2:0], 1'b0};
			end
		end
	end

	// the last control bit enables both of the two trailing segments
	assign cursorDraw = |(segShift & {ctrl.cursorSeg[2], ctrl.cursorSeg});

	always_comb begin
		colour = palette[{shifter[7], shifter[5], shifter[3], shifter[1]}];
		displayed = disEnReg && !rowAddr[3];
		if (ctrl.teletext) begin
			pixel = ttxRgb;
		end else if (!displayed) begin
			pixel = '0;
		end else if (colour.flash && ctrl.flash) begin
			pixel = colour.rgb;
		end else begin
			pixel = ~colour.rgb;
		end
	end

	always_ff @(posedge CLK) begin
		rgb <= cursorDraw ? ~pixel : pixel;
	end

	// character strobe comes from exactly one source, and both sources land on en2v
	charEnSource: assert property (
		@(posedge CLK) disable iff (!nRESET)
		charEn |-> en.en2v && $onehot({ctrl.fastCrtc, !ctrl.fastCrtc && en.en1})
	);

endmodule

`default_nettype wire

//--- hdl/displayControl.sv
`timescale 1ns/1ns
`default_nettype none

module displayControl
	import crtcPkg::*, videoPkg::*;
#(
	parameter int FS_ADDR_W = 14
) (
	input wire CLK,
	input wire nRESET,
	input wire procEn,
	input wire rnw,
	input wire a0,
	input wire ncsCrtc,
	input wire ncsUla,
	input wire [7:0] cpuWrData,
	output wire [7:0] cpuRdData,
	input wire [7:0] vData,
	input wire rgbPixel ttxRgb,
	output wire hsync,
	output wire vsync,
	output wire txtMode,
	output wire rgbPixel rgb,
	output wire [FS_ADDR_W-1:0] fsAddr,
	output wire [4:0] rowAddr
);

	clockEn en;
	crtcTiming timing;
	crtcTiming crtcClk;
	logic ulaCharEn;

	// the ULA picks the character rate and clocks the CRTC with it
	assign crtcClk = '{charEn: ulaCharEn, default: 1'b0};
	assign hsync = timing.hsync;
	assign vsync = timing.vsync;

	clockEnables clocks (
		.CLK(CLK),
		.nRESET(nRESET),
		.en(en)
	);

	crtc6845 #(
		.FS_ADDR_W(FS_ADDR_W)
	) crtc (
		.CLK(CLK),
		.nRESET(nRESET),
		.charEn(crtcClk.charEn),
		.procEn(procEn),
		.rnw(rnw),
		.a0(a0),
		.ncsCrtc(ncsCrtc),
		.cpuWrData(cpuWrData),
		.cpuRdData(cpuRdData),
		.timing(timing),
		.fsAddr(fsAddr),
		.rowAddr(rowAddr)
	);

	videoUla ula (
		.CLK(CLK),
		.nRESET(nRESET),
		.en(en),
		.timing(timing),
		.rowAddr(rowAddr),
		.procEn(procEn),
		.a0(a0),
		.ncsUla(ncsUla),
		.cpuWrData(cpuWrData),
		.vData(vData),
		.ttxRgb(ttxRgb),
		.charEn(ulaCharEn),
		.txtMode(txtMode),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

//--- tests/displayChecks.svh
task automatic failRun(input string why);
	$display("%s", why);
	$display("TB FAILED");
	$fatal(1);
endtask

task automatic checkRgb(input string name, input rgbPixel got, input rgbPixel exp);
	if (got !== exp) begin
		$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		failRun("colour output differs from the reference rule");
	end
endtask

task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		$display("mismatch at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
		failRun("byte value differs from the expected one");
	end
endtask

task automatic checkCount(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		failRun("count differs from the expected one");
	end
endtask

// pixel bits 7, 5, 3 and 1 form the palette index
function automatic logic [3:0] pixelIndex(input logic [7:0] v);
	return {v[7], v[5], v[3], v[1]};
endfunction

// reference colour for one character cell
function automatic rgbPixel expectedRgb(
	input ulaControl ctrl,
	input paletteEntry entry,
	input logic displayed,
	input rgbPixel ttx,
	input logic cursorOn
);
	rgbPixel colour;
	if (ctrl.teletext) begin
		colour = ttx;
	end else if (!displayed) begin
		colour = 3'd0;
	end else if (entry.flash && ctrl.flash) begin
		colour = entry.rgb;
	end else begin
		colour = ~entry.rgb;
	end
	// the cursor inverts whatever the rule gives
	if (cursorOn) begin
		colour = ~colour;
	end
	return colour;
endfunction

//--- tests/displayControlTb.sv
`timescale 1ns/1ns
`default_nettype none

module displayControlTb
	import crtcPkg::*, videoPkg::*;
;

	typedef struct packed {
		logic [7:0] hTotal;
		logic [7:0] hDisp;
		logic [7:0] hSyncPos;
		logic [7:0] syncWidth;
		logic [7:0] vTotal;
		logic [7:0] vDisp;
		logic [7:0] vSyncPos;
		logic [7:0] maxScan;
		logic [7:0] curStart;
		logic [7:0] curEnd;
		logic [15:0] startAddr;
		logic [15:0] cursorAddr;
		ulaControl ctrl;
		logic useAddr;
		logic [7:0] pattern;
		rgbPixel ttx;
		int expHPeriod;
		int expFrame;
	} testEntry;

	localparam int WAIT_LIMIT = 20000;

	logic CLK = 1'b0;
	logic nRESET;
	logic procEn;
	logic rnw;
	logic a0;
	logic ncsCrtc;
	logic ncsUla;
	logic [7:0] cpuWrData;
	logic [7:0] cpuRdData;
	logic [7:0] vData;
	rgbPixel ttxRgb;
	logic hsync;
	logic vsync;
	logic txtMode;
	rgbPixel rgb;
	logic [13:0] fsAddr;
	logic [4:0] rowAddr;

	testEntry entries [3];
	paletteEntry palette [16];
	logic useAddr;
	logic [7:0] pattern;

	`include "displayChecks.svh"

	displayControl #(
		.FS_ADDR_W(14)
	) dut (
		.CLK(CLK),
		.nRESET(nRESET),
		.procEn(procEn),
		.rnw(rnw),
		.a0(a0),
		.ncsCrtc(ncsCrtc),
		.ncsUla(ncsUla),
		.cpuWrData(cpuWrData),
		.cpuRdData(cpuRdData),
		.vData(vData),
		.ttxRgb(ttxRgb),
		.hsync(hsync),
		.vsync(vsync),
		.txtMode(txtMode),
		.rgb(rgb),
		.fsAddr(fsAddr),
		.rowAddr(rowAddr)
	);

	always #50 CLK = ~CLK;

	// video memory answers with the low address byte or a fixed pattern
	assign vData = useAddr ? fsAddr[7:0] : pattern;

	function automatic logic sigValue(input int sel);
		case (sel)
			0: return hsync;
			1: return vsync;
			default: return dut.timing.disEn;
		endcase
	endfunction

	// counts falling edges until the signal reaches the level
	task automatic countUntil(input int sel, input logic level, output int cycles);
		cycles = 0;
		while (sigValue(sel) !== level) begin
			@(negedge CLK);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("timeout waiting for timing signal %0d to reach %0b", sel, level);
				failRun("the display timing stopped");
			end
		end
	endtask

	task automatic waitRise(input int sel);
		int n;
		countUntil(sel, 1'b0, n);
		countUntil(sel, 1'b1, n);
	endtask

	task automatic busWrite(input logic crtcSel, input logic addr, input logic [7:0] data);
		@(negedge CLK);
		procEn = 1'b1;
		rnw = 1'b0;
		a0 = addr;
		ncsCrtc = !crtcSel;
		ncsUla = crtcSel;
		cpuWrData = data;
		@(negedge CLK);
		procEn = 1'b0;
		rnw = 1'b1;
		ncsCrtc = 1'b1;
		ncsUla = 1'b1;
	endtask

	task automatic crtcRead(input int regNum, output logic [7:0] value);
		busWrite(1'b1, 1'b0, 8'(regNum));
		a0 = 1'b1;
		ncsCrtc = 1'b0;
		@(negedge CLK);
		value = cpuRdData;
		ncsCrtc = 1'b1;
	endtask

	function automatic logic [7:0] regValue(input testEntry t, input int regNum);
		case (regNum)
			0: return t.hTotal;
			1: return t.hDisp;
			2: return t.hSyncPos;
			3: return t.syncWidth;
			4: return t.vTotal;
			6: return t.vDisp;
			7: return t.vSyncPos;
			9: return t.maxScan;
			10: return t.curStart;
			11: return t.curEnd;
			12: return t.startAddr[15:8];
			13: return t.startAddr[7:0];
			14: return t.cursorAddr[15:8];
			15: return t.cursorAddr[7:0];
			default: return 8'h00;
		endcase
	endfunction

	task automatic programEntry(input testEntry t);
		logic [7:0] value;
		for (int r = 0; r < 16; r++) begin
			busWrite(1'b1, 1'b0, 8'(r));
			busWrite(1'b1, 1'b1, regValue(t, r));
		end
		// only the cursor pair reads back
		for (int r = 0; r < 16; r++) begin
			crtcRead(r, value);
			checkByte($sformatf("cpuRdData reg %0d", r), value, r >= 14 ? regValue(t, r) : 8'h00);
		end
		for (int i = 0; i < 16; i++) begin
			palette[i] = paletteEntry'($urandom & 15);
			busWrite(1'b0, 1'b1, {4'(i), 4'(palette[i])});
		end
		busWrite(1'b0, 1'b0, 8'(t.ctrl));
		useAddr = t.useAddr;
		pattern = t.pattern;
		ttxRgb = t.ttx;
	endtask

	// checks every displayed line of one frame plus the cell after each line
	task automatic checkFrame(input testEntry t, input int charCycles);
		int scans;
		int row;
		int scan;
		logic [13:0] lineAddr;
		logic displayed;
		logic cursorOn;
		scans = t.maxScan + 1;
		for (int line = 0; line < t.vDisp * scans; line++) begin
			waitRise(2);
			row = line / scans;
			scan = line % scans;
			lineAddr = 14'(t.startAddr + row * t.hDisp);
			checkCount("fsAddr", fsAddr, lineAddr);
			checkCount("rowAddr", rowAddr, scan);
			for (int k = 0; k <= t.hDisp; k++) begin
				repeat (k == 0 ? charCycles + charCycles / 2 : charCycles) @(negedge CLK);
				displayed = (k < t.hDisp) && !scan[3];
				cursorOn = (k < t.hDisp) && t.ctrl.cursorSeg[0] &&
					(lineAddr + 14'(k) == t.cursorAddr[13:0]) &&
					(scan >= t.curStart) && (scan <= t.curEnd);
				checkRgb("rgb", rgb, expectedRgb(t.ctrl, palette[pixelIndex(t.pattern)],
					displayed, t.ttx, cursorOn));
			end
		end
	endtask

	initial begin
		int charCycles;
		int high;
		int low;
		void'($urandom(60));
		nRESET = 1'b0;
		procEn = 1'b0;
		rnw = 1'b1;
		a0 = 1'b0;
		ncsCrtc = 1'b1;
		ncsUla = 1'b1;
		cpuWrData = 8'h00;
		ttxRgb = 3'd0;
		useAddr = 1'b0;
		pattern = 8'h00;

		// slow CRTC with row 8 and 9 blanked, fast CRTC, then teletext
		entries[0] = '{8'd7, 8'd4, 8'd5, 8'h22, 8'd4, 8'd2, 8'd3, 8'd9, 8'd1, 8'd2,
			16'h0100, 16'h0102, 8'h21, 1'b0, 8'hC3, 3'd0, 128, 6400};
		entries[1] = '{8'd9, 8'd6, 8'd7, 8'h31, 8'd5, 8'd3, 8'd4, 8'd3, 8'd0, 8'd3,
			16'h0200, 16'h0209, 8'h34, 1'b0, 8'h3C, 3'd0, 80, 1920};
		entries[2] = '{8'd9, 8'd6, 8'd7, 8'h31, 8'd5, 8'd3, 8'd4, 8'd3, 8'd0, 8'd3,
			16'h0200, 16'h3FFF, 8'h12, 1'b1, 8'hFF, 3'd5, 80, 1920};

		foreach (entries[i]) begin
			@(negedge CLK);
			nRESET = 1'b0;
			repeat (8) @(negedge CLK);
			nRESET = 1'b1;
			programEntry(entries[i]);
			checkByte("txtMode", {7'd0, txtMode}, {7'd0, entries[i].ctrl.teletext});
			charCycles = entries[i].ctrl.fastCrtc ? 8 : 16;

			waitRise(1);
			waitRise(0);
			countUntil(0, 1'b0, high);
			countUntil(0, 1'b1, low);
			checkCount("hsync high", high, entries[i].syncWidth[3:0] * charCycles);
			checkCount("hsync period", high + low, entries[i].expHPeriod);

			waitRise(1);
			countUntil(1, 1'b0, high);
			countUntil(1, 1'b1, low);
			checkCount("vsync period", high + low, entries[i].expFrame);
			checkFrame(entries[i], charCycles);
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tests
hdl/crtcPkg.sv
hdl/videoPkg.sv
hdl/clockEnables.sv
hdl/crtc6845.sv
hdl/videoUla.sv
hdl/displayControl.sv
tests/displayControlTb.sv

//--- run.sh
#!/bin/sh
# builds and runs the display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module displayControlTb -o displayControlTb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/displayControlTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
